/* sim.f */
design/rs232_pkg.sv
design/rs232_tx.sv
design/rs232_rx.sv
design/rx_fifo.sv
design/wb_regs.sv
design/rs232_top.sv
tb/tb_clock.sv
tb/rs232_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rs232_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 86286
VFLAGS    ?= --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/rs232_tb.sv */
`timescale 1ns/1ns

module rs232_tb
#(
    parameter int SEED = 86286
);

    // Start, data, parity and stop bits of one frame
    localparam int FRAME_CYCLES = (2 + rs232_pkg::DATA_BITS + rs232_pkg::STOP_BITS)
                                * rs232_pkg::TICKS_PER_BIT;
    localparam int WATCHDOG_NS  = (40 * FRAME_CYCLES + 16) * 4;
    localparam int ACK_LIMIT    = 2 * FRAME_CYCLES;
    localparam int POLL_LIMIT   = 2 * FRAME_CYCLES;
    localparam int FLOW_FRAMES  = rs232_pkg::FIFO_DEPTH - rs232_pkg::CTS_MARGIN + 1;

    logic               clk;
    logic               rst;
    rs232_pkg::wb_req_t wb_req;
    rs232_pkg::wb_rsp_t wb_rsp;
    logic               rx;
    logic               rts;
    logic               tx;
    logic               cts;

    int                 mismatches = 0;
    int                 failures   = 0;
    integer             seed;
    rs232_pkg::byte_t   tx_expected[$];   // Bytes written, in the order tx must show them
    rs232_pkg::byte_t   rx_expected[$];

    tb_clock clock_i (.clk, .rst);

    rs232_top dut_i (.clk, .rst, .wb_req, .wb_rsp, .rx, .rts, .tx, .cts);

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else
        begin
            mismatches++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error: %s", what);
    endtask

    a_cts_follows_rts: assert property (@(posedge clk) disable iff (rst) !rts |=> !cts)
        else report_failure("cts still high one cycle after rts went low");

    a_reset_state: assert property (@(posedge clk) $fell(rst) |-> tx && !cts)
    else
    begin
        mismatches++;
        $display("Mismatch {tx,cts} after reset: got 0x%h, expected 0x%h", {tx, cts}, 2'b10);
    end

    //////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////
    task automatic wb_cycle(input logic we, input rs232_pkg::reg_addr_e addr,
                            input rs232_pkg::byte_t wdata, output rs232_pkg::byte_t rdata,
                            output int waited);
        waited = 0;
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: logic'(addr), dat: wdata};
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (!wb_rsp.ack && waited < ACK_LIMIT);
        rdata  = wb_rsp.dat;
        wb_req = '0;                       // Drop stb once the slave has answered
        assert (wb_rsp.ack) else report_failure("Wishbone access was never acknowledged");
    endtask

    task automatic wb_write(input rs232_pkg::reg_addr_e addr, input rs232_pkg::byte_t data,
                            output int waited);
        rs232_pkg::byte_t unused;
        wb_cycle(1'b1, addr, data, unused, waited);
    endtask

    task automatic wb_read(input rs232_pkg::reg_addr_e addr, output rs232_pkg::byte_t data);
        int waited;
        wb_cycle(1'b0, addr, 8'h00, data, waited);
    endtask

    task automatic wait_tx_idle();
        rs232_pkg::byte_t st;
        int               polls;
        polls = 0;
        do
        begin
            wb_read(rs232_pkg::REG_STATUS, st);
            polls++;
        end
        while (st[1] && polls < POLL_LIMIT);
        assert (!st[1]) else report_failure("transmitter never went idle");
        assert (tx_expected.size() == 0) else report_failure("a written byte never left on tx");
    endtask

    task automatic wait_cts_high(input int limit);
        int n;
        n = 0;
        while (!cts && n < limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (cts) else report_failure("cts did not rise in time");
    endtask

    //////////////////////////////////////////////////
    // Serial peer
    //////////////////////////////////////////////////
    task automatic drive_bit(input logic v);
        @(posedge clk);
        #1 rx = v;
        repeat (rs232_pkg::TICKS_PER_BIT - 1) @(posedge clk);
    endtask

    // Even parity, inverted on request
    task automatic send_frame(input rs232_pkg::byte_t data, input logic bad_parity);
        drive_bit(1'b0);
        for (int i = 0; i < rs232_pkg::DATA_BITS; i++)
            drive_bit(data[i]);
        drive_bit((^data) ^ bad_parity);
        repeat (rs232_pkg::STOP_BITS) drive_bit(1'b1);
    endtask

    // Decodes tx at mid-bit, sampled on the falling clock edge
    initial
    begin : tx_monitor
        rs232_pkg::byte_t got;
        rs232_pkg::byte_t exp;
        logic             par;
        forever
        begin
            @(negedge clk);
            if (!rst && tx === 1'b0)
            begin
                repeat (rs232_pkg::HALF_TICKS - 1) @(negedge clk);
                check_value("tx start bit", tx, 1'b0);
                for (int i = 0; i < rs232_pkg::DATA_BITS; i++)
                begin
                    repeat (rs232_pkg::TICKS_PER_BIT) @(negedge clk);
                    got[i] = tx;
                end
                repeat (rs232_pkg::TICKS_PER_BIT) @(negedge clk);
                par = tx;
                repeat (rs232_pkg::TICKS_PER_BIT) @(negedge clk);
                check_value("tx stop bit", tx, 1'b1);
                if (tx_expected.size() == 0)
                    report_failure("frame on tx without a written byte");
                else
                begin
                    exp = tx_expected.pop_front();
                    check_value("tx data", got, exp);
                    check_value("tx parity bit", par, ^exp);
                end
            end
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial
    begin : stimulus
        rs232_pkg::byte_t data;
        rs232_pkg::byte_t rd;
        int               waited;
        seed   = SEED;
        wb_req = '0;
        rx     = 1'b1;
        rts    = 1'b0;
        wait (!rst);

        wb_read(rs232_pkg::REG_STATUS, rd);
        check_value("status after reset", rd, 8'h00);
        wb_read(rs232_pkg::REG_DATA, rd);
        check_value("data on empty FIFO", rd, 8'h00);

        for (int n = 0; n < 6; n++)
        begin
            data = rs232_pkg::byte_t'($random(seed));
            tx_expected.push_back(data);
            wb_write(rs232_pkg::REG_DATA, data, waited);
            wb_read(rs232_pkg::REG_STATUS, rd);
            check_value("status tx_busy", rd[1], 1'b1);
            wait_tx_idle();
        end

        @(posedge clk);
        #1 rts = 1'b1;
        wait_cts_high(8);
        for (int n = 0; n < 5; n++)
        begin
            data = rs232_pkg::byte_t'($random(seed));
            rx_expected.push_back(data);
            send_frame(data, 1'b0);
        end
        wb_read(rs232_pkg::REG_STATUS, rd);
        check_value("status rx_avail", rd[0], 1'b1);
        while (rx_expected.size() > 0)
        begin
            wb_read(rs232_pkg::REG_DATA, rd);
            check_value("rx data", rd, rx_expected.pop_front());
        end

        send_frame(rs232_pkg::byte_t'($random(seed)), 1'b1);
        wb_read(rs232_pkg::REG_STATUS, rd);
        check_value("status after parity error", rd, 8'h04);
        wb_read(rs232_pkg::REG_STATUS, rd);
        check_value("status after clear", rd, 8'h00);

        // Flow control, peer withdraws first
        @(posedge clk);
        #1 rts = 1'b0;
        repeat (8) @(posedge clk);
        check_value("cts with rts low", cts, 1'b0);
        #1 rts = 1'b1;
        wait_cts_high(8);
        for (int n = 0; n < FLOW_FRAMES; n++)
        begin
            data = rs232_pkg::byte_t'($random(seed));
            rx_expected.push_back(data);
            send_frame(data, 1'b0);
        end
        check_value("cts with FIFO nearly full", cts, 1'b0);
        wb_read(rs232_pkg::REG_DATA, rd);
        check_value("rx data", rd, rx_expected.pop_front());
        wait_cts_high(rs232_pkg::TICKS_PER_BIT);
        while (rx_expected.size() > 0)
        begin
            wb_read(rs232_pkg::REG_DATA, rd);
            check_value("rx data", rd, rx_expected.pop_front());
        end

        // Back-pressure on the holding register
        for (int n = 0; n < 3; n++)
        begin
            data = rs232_pkg::byte_t'($random(seed));
            tx_expected.push_back(data);
            wb_write(rs232_pkg::REG_DATA, data, waited);
        end
        assert (waited > rs232_pkg::TICKS_PER_BIT)
            else report_failure("write to a full holding register was acked early");
        wait_tx_idle();

        repeat (4) @(posedge clk);
        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;      // Released just after the edge like any other input
    end

    always #2 clk = ~clk;   // 4 ns period

endmodule

/* design/rs232_top.sv */
`timescale 1ns/1ns

module rs232_top
(
    input  logic               clk,
    input  logic               rst,
    input  rs232_pkg::wb_req_t wb_req,
    output rs232_pkg::wb_rsp_t wb_rsp,
    input  logic               rx,
    input  logic               rts,
    output logic               tx,
    output logic               cts
);

    //////////////////////////////////////////////////
    // Transmit path
    //////////////////////////////////////////////////
    logic             tx_valid;
    rs232_pkg::byte_t tx_byte;
    logic             tx_taken;
    logic             tx_busy;

    //////////////////////////////////////////////////
    // Receive path
    //////////////////////////////////////////////////
    logic             push;
    rs232_pkg::byte_t push_byte;
    logic             parity_err_pulse;
    rs232_pkg::byte_t head;
    logic             empty;
    logic             room;
    logic             pop;

    // Port names match the nets above one to one
    rs232_tx tx_i (.*);

    rs232_rx rx_i (.*);

    rx_fifo fifo_i (.*);

    wb_regs regs_i (.*);

endmodule

/* design/wb_regs.sv */
`timescale 1ns/1ns

module wb_regs
(
    input  logic               clk,
    input  logic               rst,
    input  rs232_pkg::wb_req_t wb_req,
    output rs232_pkg::wb_rsp_t wb_rsp,
    output logic               tx_valid,
    output rs232_pkg::byte_t   tx_byte,
    input  logic               tx_taken,
    input  logic               tx_busy,
    input  rs232_pkg::byte_t   head,
    input  logic               empty,
    output logic               pop,
    input  logic               parity_err_pulse
);

    rs232_pkg::reg_addr_e addr;
    rs232_pkg::byte_t     status;
    rs232_pkg::byte_t     rd_q;
    logic                 ack_q;
    logic                 parity_err;
    logic                 req;
    logic                 hold_full;
    logic                 accept;
    logic                 wr_data;
    logic                 rd_status;

    assign addr      = rs232_pkg::reg_addr_e'(wb_req.adr);
    assign req       = wb_req.cyc && wb_req.stb && !ack_q;
    assign hold_full = tx_valid && !tx_taken;   // Frees up as the transmitter loads

    // Write to a full holding register waits for it to drain
    assign accept    = req && !(wb_req.we && addr == rs232_pkg::REG_DATA && hold_full);
    assign wr_data   = accept && wb_req.we && addr == rs232_pkg::REG_DATA;
    assign rd_status = accept && !wb_req.we && addr == rs232_pkg::REG_STATUS;
    assign pop       = accept && !wb_req.we && addr == rs232_pkg::REG_DATA;

    // Bit 0 rx_avail, bit 1 tx_busy, bit 2 parity_err
    assign status = rs232_pkg::byte_t'({parity_err, tx_busy | tx_valid, !empty});

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

    always_ff @(posedge clk)
    begin
        if (wr_data)
            tx_byte <= wb_req.dat;
        if (accept && !wb_req.we)
            rd_q <= (addr == rs232_pkg::REG_STATUS) ? status : (empty ? '0 : head);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack_q      <= 1'b0;
            tx_valid   <= 1'b0;
            parity_err <= 1'b0;
        end
        else
        begin
            ack_q <= accept;
            if (wr_data)
                tx_valid <= 1'b1;
            else if (tx_taken)
                tx_valid <= 1'b0;
            if (parity_err_pulse)
                parity_err <= 1'b1;          // A new error wins over the clear
            else if (rd_status)
                parity_err <= 1'b0;
        end
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack_q |=> !ack_q);

endmodule

/* design/rx_fifo.sv */
`timescale 1ns/1ns

module rx_fifo
(
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  rs232_pkg::byte_t push_byte,
    input  logic             pop,
    output rs232_pkg::byte_t head,
    output logic             empty,
    output logic             room
);

    rs232_pkg::byte_t                          mem [rs232_pkg::FIFO_DEPTH];
    logic [$clog2(rs232_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(rs232_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
    logic [$clog2(rs232_pkg::FIFO_DEPTH+1)-1:0] count;
    logic                                      do_push;
    logic                                      do_pop;

    assign do_push = push;                // Receiver only pushes while room is up
    assign do_pop  = pop && !empty;       // Pop on empty is ignored
    assign empty   = (count == '0);
    assign room    = (int'(count) + rs232_pkg::CTS_MARGIN <= rs232_pkg::FIFO_DEPTH);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_byte;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (int'(wr_ptr) == rs232_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (int'(rd_ptr) == rs232_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        int'(count) <= rs232_pkg::FIFO_DEPTH);

endmodule

/* design/rs232_rx.sv */
`timescale 1ns/1ns

module rs232_rx
(
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,
    input  logic             rts,
    input  logic             room,
    output logic             cts,
    output logic             push,
    output rs232_pkg::byte_t push_byte,
    output logic             parity_err_pulse
);

    rs232_pkg::rx_state_e                        state;
    logic [$clog2(rs232_pkg::TICKS_PER_BIT)-1:0] tick_cnt;
    logic [$clog2(rs232_pkg::DATA_BITS)-1:0]     bit_idx;
    rs232_pkg::byte_t                            shift_q;
    logic                                        bad_q;
    logic                                        rx_q;
    logic                                        fall;
    logic                                        sample;
    logic                                        counting;

    assign fall = rx_q & ~rx;

    // Start bit is checked at half a bit, every later bit one full bit on
    assign sample = (state == rs232_pkg::RX_START)
                  ? (int'(tick_cnt) == rs232_pkg::HALF_TICKS - 1)
                  : (int'(tick_cnt) == rs232_pkg::TICKS_PER_BIT - 1);

    assign counting = state inside {rs232_pkg::RX_START, rs232_pkg::RX_DATA,
                                    rs232_pkg::RX_PARITY, rs232_pkg::RX_STOP};

    assign push             = (state == rs232_pkg::RX_DONE) && !bad_q;
    assign parity_err_pulse = (state == rs232_pkg::RX_DONE) && bad_q;
    assign push_byte        = shift_q;

    always_ff @(posedge clk)
    begin
        if (state == rs232_pkg::RX_DATA && sample)
            shift_q <= {rx, shift_q[rs232_pkg::DATA_BITS-1:1]};
    end

    //////////////////////////////////////////////////
    // Receive FSM and flow control
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= rs232_pkg::RX_WAIT_CTS;
            tick_cnt <= '0;
            bit_idx  <= '0;
            bad_q    <= 1'b0;
            rx_q     <= 1'b1;
            cts      <= 1'b0;
        end
        else
        begin
            rx_q     <= rx;
            tick_cnt <= (!counting || sample) ? '0 : tick_cnt + 1'b1;
            case (state)
                rs232_pkg::RX_WAIT_CTS:
                begin
                    cts <= rts && room;
                    if (rts && room)
                        state <= rs232_pkg::RX_WAIT_START;
                end
                rs232_pkg::RX_WAIT_START:
                begin
                    if (!(rts && room))
                    begin
                        cts   <= 1'b0;              // Peer withdrew or FIFO filling up
                        state <= rs232_pkg::RX_WAIT_CTS;
                    end
                    else if (fall)
                    begin
                        bad_q <= 1'b0;
                        state <= rs232_pkg::RX_START;
                    end
                end
                rs232_pkg::RX_START:
                begin
                    if (sample && !rx)
                    begin
                        bit_idx <= '0;
                        state   <= rs232_pkg::RX_DATA;
                    end
                    else if (sample)
                    begin
                        state <= rs232_pkg::RX_WAIT_START;   // Glitch, not a start bit
                    end
                end
                rs232_pkg::RX_DATA:
                begin
                    if (sample && int'(bit_idx) == rs232_pkg::DATA_BITS - 1)
                        state <= (rs232_pkg::PARITY == rs232_pkg::PARITY_NONE)
                               ? rs232_pkg::RX_STOP : rs232_pkg::RX_PARITY;
                    else if (sample)
                        bit_idx <= bit_idx + 1'b1;
                end
                rs232_pkg::RX_PARITY:
                begin
                    if (sample)
                    begin
                        bad_q <= rx ^ (^shift_q)
                               ^ (rs232_pkg::PARITY == rs232_pkg::PARITY_ODD);
                        state <= rs232_pkg::RX_STOP;
                    end
                end
                rs232_pkg::RX_STOP:
                begin
                    // Low stop bit is a framing error, the byte is dropped
                    if (sample)
                        state <= rx ? rs232_pkg::RX_DONE : rs232_pkg::RX_WAIT_CTS;
                end
                default:
                begin
                    state <= rs232_pkg::RX_WAIT_CTS;   // RX_DONE lasts one cycle
                end
            endcase
        end
    end

    a_push_has_room: assert property (@(posedge clk) disable iff (rst) push |-> room);

endmodule

/* design/rs232_tx.sv */
`timescale 1ns/1ns

module rs232_tx
(
    input  logic             clk,
    input  logic             rst,
    input  logic             tx_valid,
    input  rs232_pkg::byte_t tx_byte,
    output logic             tx_taken,
    output logic             tx_busy,
    output logic             tx
);

    rs232_pkg::tx_state_e                        state;
    logic [$clog2(rs232_pkg::TICKS_PER_BIT)-1:0] tick_cnt;
    logic [$clog2(rs232_pkg::DATA_BITS)-1:0]     bit_idx;
    rs232_pkg::byte_t                            shift_q;
    logic                                        par_q;
    logic                                        bit_end;

    assign bit_end = (int'(tick_cnt) == rs232_pkg::TICKS_PER_BIT - 1);
    assign tx_busy = (state != rs232_pkg::TX_IDLE);

    // Byte and its parity bit, captured at load
    always_ff @(posedge clk)
    begin
        if (state == rs232_pkg::TX_IDLE && tx_valid)
        begin
            shift_q <= tx_byte;
            par_q   <= (^tx_byte) ^ (rs232_pkg::PARITY == rs232_pkg::PARITY_ODD);
        end
        else if (state == rs232_pkg::TX_DATA && bit_end)
        begin
            shift_q <= shift_q >> 1;   // Next data bit into position 1
        end
    end

    //////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= rs232_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx_taken <= 1'b0;
            tx       <= 1'b1;             // Line idles high
        end
        else
        begin
            tx_taken <= 1'b0;
            tick_cnt <= (state == rs232_pkg::TX_IDLE || bit_end) ? '0 : tick_cnt + 1'b1;
            case (state)
                rs232_pkg::TX_IDLE:
                begin
                    if (tx_valid)
                    begin
                        state    <= rs232_pkg::TX_START;
                        tx       <= 1'b0;   // Start bit
                        tx_taken <= 1'b1;
                    end
                end
                rs232_pkg::TX_START:
                begin
                    if (bit_end)
                    begin
                        state   <= rs232_pkg::TX_DATA;
                        tx      <= shift_q[0];
                        bit_idx <= '0;
                    end
                end
                rs232_pkg::TX_DATA:
                begin
                    if (bit_end && int'(bit_idx) == rs232_pkg::DATA_BITS - 1)
                    begin
                        bit_idx <= '0;
                        if (rs232_pkg::PARITY == rs232_pkg::PARITY_NONE)
                        begin
                            state <= rs232_pkg::TX_STOP;
                            tx    <= 1'b1;
                        end
                        else
                        begin
                            state <= rs232_pkg::TX_PARITY;
                            tx    <= par_q;
                        end
                    end
                    else if (bit_end)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        tx      <= shift_q[1];   // LSB first
                    end
                end
                rs232_pkg::TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        state <= rs232_pkg::TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                rs232_pkg::TX_STOP:
                begin
                    if (bit_end && int'(bit_idx) == rs232_pkg::STOP_BITS - 1)
                        state <= rs232_pkg::TX_IDLE;
                    else if (bit_end)
                        bit_idx <= bit_idx + 1'b1;   // Second stop bit
                end
                default:
                begin
                    state <= rs232_pkg::TX_IDLE;
                end
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
        state == rs232_pkg::TX_IDLE |-> tx);

endmodule

/* design/rs232_pkg.sv */
package rs232_pkg;

    //////////////////////////////////////////////////
    // Frame and buffer sizes
    //////////////////////////////////////////////////
    localparam int TICKS_PER_BIT = 16;               // Clock cycles per serial bit
    localparam int HALF_TICKS    = TICKS_PER_BIT / 2; // Mid-bit sampling point
    localparam int DATA_BITS     = 8;
    localparam int STOP_BITS     = 1;                // 1 or 2
    localparam int FIFO_DEPTH    = 8;
    localparam int CTS_MARGIN    = 2;                // Free entries needed to keep cts up

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD
    } parity_e;

    localparam parity_e PARITY = PARITY_EVEN;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_WAIT_CTS,
        RX_WAIT_START,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_DONE
    } rx_state_e;

    typedef enum logic [0:0] {
        REG_DATA   = 1'b0,
        REG_STATUS = 1'b1
    } reg_addr_e;

    //////////////////////////////////////////////////
    // Data and bus types
    //////////////////////////////////////////////////
    typedef logic [7:0] byte_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        logic  adr;
        byte_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        byte_t dat;
    } wb_rsp_t;

endpackage
